// ==== project.f ====
hdl/id_pkg.sv
hdl/id_decoder.sv
hdl/id_operands.sv
hdl/id_fsm.sv
hdl/id_stage.sv
verif/tb_id_stage.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the decode stage testbench with Verilator from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing -f project.f --top-module tb_id_stage -o sim_id_stage &&
./obj_dir/sim_id_stage ||
{
  echo "run failed"
  exit 1
}

// ==== verif/id_stim.txt ====
# instr pc rdata_a rdata_b br_dec resp_delay incr last | illegal aluop op_a op_b raddr_a raddr_b
# ren_a ren_b waddr we lsu_req lsu_we lsu_type sext op_a_c2 op_b_c2 pcset_cycle latency (all hex)
002081b3 00000100 00001000 cafebabe 0 0 0 00000000 0 0 00001000 cafebabe 01 02 1 1 03 1 0 0 0 0 00000000 00000000 0 1
407302b3 00000100 00001000 cafebabe 0 0 0 00000000 0 1 00001000 cafebabe 06 07 1 1 05 1 0 0 0 0 00000000 00000000 0 1
40a4d433 00000100 00001000 cafebabe 0 0 0 00000000 0 7 00001000 cafebabe 09 0a 1 1 08 1 0 0 0 0 00000000 00000000 0 1
fff10093 00000100 00001000 cafebabe 0 0 0 00000000 0 0 00001000 ffffffff 02 1f 1 0 01 1 0 0 0 0 00000000 00000000 0 1
00321213 00000100 00001000 cafebabe 0 0 0 00000000 0 5 00001000 00000003 04 03 1 0 04 1 0 0 0 0 00000000 00000000 0 1
41f35313 00000100 00001000 cafebabe 0 0 0 00000000 0 7 00001000 0000041f 06 1f 1 0 06 1 0 0 0 0 00000000 00000000 0 1
00508013 00000100 00001000 cafebabe 0 0 0 00000000 0 0 00001000 00000005 01 05 1 0 00 0 0 0 0 0 00000000 00000000 0 1
123453b7 00000100 00001000 cafebabe 0 0 0 00000000 0 0 00000000 12345000 08 03 0 0 07 1 0 0 0 0 00000000 00000000 0 1
fffff497 00000100 00001000 cafebabe 0 0 0 00000000 0 0 00000100 fffff000 1f 1f 0 0 09 1 0 0 0 0 00000000 00000000 0 1
0080a283 00000200 00001000 cafebabe 0 0 0 00000000 0 0 00001000 00000008 01 08 1 0 05 1 1 0 0 1 00001000 00000008 0 2
ffc14303 00000200 00002000 12345678 0 1 0 00000000 0 0 00002000 fffffffc 02 1c 1 0 06 1 1 0 3 0 00002000 fffffffc 0 3
00219383 00000200 00003000 12345678 0 3 0 00000000 0 0 00003000 00000002 03 02 1 0 07 1 1 0 2 1 00003000 00000002 0 5
0020a623 00000200 00001000 deadbeef 0 2 0 00000000 0 0 00001000 0000000c 01 02 1 1 0c 0 1 1 0 0 00001000 0000000c 0 4
fe428fa3 00000200 00005000 000000a5 0 0 0 00000000 0 0 00005000 ffffffff 05 04 1 1 1f 0 1 1 3 0 00005000 ffffffff 0 2
0080a283 00000200 00001000 cafebabe 0 1 1 00002002 0 0 00002002 00000004 01 08 1 0 05 1 1 0 0 1 00002002 00000004 0 3
00208863 00000300 00001000 cafebabe 0 0 0 00000000 0 a 00001000 cafebabe 01 02 1 1 10 0 0 0 0 0 00000000 00000000 0 1
00209863 00000300 00001000 cafebabe 1 0 0 00000000 0 b 00001000 cafebabe 01 02 1 1 10 0 0 0 0 0 00000300 00000010 2 2
fe41cce3 00000300 00000007 00000009 1 0 0 00000000 0 c 00000007 00000009 03 04 1 1 19 0 0 0 0 0 00000300 fffffff8 2 2
0062f463 00000300 00000001 00000002 0 0 0 00000000 0 f 00000001 00000002 05 06 1 1 08 0 0 0 0 0 00000000 00000000 0 1
010000ef 00000400 00001000 cafebabe 0 0 0 00000000 0 0 00000400 00000010 00 10 0 0 01 1 0 0 0 0 00000400 00000004 1 2
004302e7 00000400 00008000 cafebabe 0 0 0 00000000 0 0 00008000 00000004 06 04 1 0 05 1 0 0 0 0 00000400 00000004 1 2
ffdff06f 00000400 00001000 cafebabe 0 0 0 00000000 0 0 00000400 fffffffc 1f 1d 0 0 00 0 0 0 0 0 00000400 00000004 1 2
0000007f 00000500 00001000 cafebabe 0 0 0 00000000 1 0 00001000 00000000 00 00 0 0 00 0 0 0 0 0 00000000 00000000 0 1
022081b3 00000500 00001000 cafebabe 0 0 0 00000000 1 0 00001000 cafebabe 01 02 0 0 03 0 0 0 0 0 00000000 00000000 0 1
40321213 00000500 00001000 cafebabe 0 0 0 00000000 1 5 00001000 00000403 04 03 0 0 04 0 0 0 0 0 00000000 00000000 0 1
00000000 00000500 00001000 cafebabe 0 0 0 00000000 1 0 00001000 00000000 00 00 0 0 00 0 0 0 0 0 00000000 00000000 0 1
0020a863 00000500 00001000 cafebabe 1 0 0 00000000 1 0 00001000 cafebabe 01 02 0 0 10 0 0 0 0 0 00000000 00000000 0 1

// ==== verif/tb_id_stage.sv ====
/*
 * Testbench of the decode stage. Reads one instruction per line from the stim
 * file, drives it until done and checks decode fields, operands, PC set and latency.
 */

`timescale 1ns/1ps

module tb_id_stage;

  logic        clk_i;
  logic        rst_ni;
  logic        instr_valid_i;
  logic [31:0] instr_rdata_i;
  logic [31:0] pc_id_i;
  logic        branch_decision_i;
  logic        ex_valid_i;
  logic        lsu_resp_valid_i;
  logic        lsu_addr_incr_req_i;
  logic [31:0] lsu_addr_last_i;
  logic [31:0] rf_rdata_a_i;
  logic [31:0] rf_rdata_b_i;

  logic        illegal_insn_o, instr_first_cycle_o, instr_id_done_o, pc_set_o;
  logic [4:0]  rf_raddr_a_o, rf_raddr_b_o, rf_waddr_o;
  logic        rf_ren_a_o, rf_ren_b_o, rf_we_o;
  logic [3:0]  alu_operator_o;
  logic [31:0] alu_operand_a_o, alu_operand_b_o;
  logic        lsu_req_o, lsu_we_o, lsu_sign_ext_o;
  logic [1:0]  lsu_type_o;
  logic [31:0] lsu_wdata_o;

  // One stim line with inputs and expected values
  logic [31:0] f [26];

  id_stage #(
    .RV32E(1'b0)
  ) i_dut (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .instr_valid_i      (instr_valid_i),
    .instr_rdata_i      (instr_rdata_i),
    .pc_id_i            (pc_id_i),
    .branch_decision_i  (branch_decision_i),
    .ex_valid_i         (ex_valid_i),
    .lsu_resp_valid_i   (lsu_resp_valid_i),
    .lsu_addr_incr_req_i(lsu_addr_incr_req_i),
    .lsu_addr_last_i    (lsu_addr_last_i),
    .rf_rdata_a_i       (rf_rdata_a_i),
    .rf_rdata_b_i       (rf_rdata_b_i),
    .illegal_insn_o     (illegal_insn_o),
    .instr_first_cycle_o(instr_first_cycle_o),
    .instr_id_done_o    (instr_id_done_o),
    .pc_set_o           (pc_set_o),
    .rf_raddr_a_o       (rf_raddr_a_o),
    .rf_raddr_b_o       (rf_raddr_b_o),
    .rf_ren_a_o         (rf_ren_a_o),
    .rf_ren_b_o         (rf_ren_b_o),
    .rf_waddr_o         (rf_waddr_o),
    .rf_we_o            (rf_we_o),
    .alu_operator_o     (alu_operator_o),
    .alu_operand_a_o    (alu_operand_a_o),
    .alu_operand_b_o    (alu_operand_b_o),
    .lsu_req_o          (lsu_req_o),
    .lsu_we_o           (lsu_we_o),
    .lsu_type_o         (lsu_type_o),
    .lsu_sign_ext_o     (lsu_sign_ext_o),
    .lsu_wdata_o        (lsu_wdata_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic fail_run(input string msg);
    $display("Error at %0t: %s", $time, msg);
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // Decode fields and operands seen in cycle 1
  task automatic check_first_cycle();
    check_val("instr_first_cycle_o", 32'(instr_first_cycle_o), 32'd1);
    check_val("illegal_insn_o", 32'(illegal_insn_o), f[8]);
    check_val("alu_operator_o", 32'(alu_operator_o), f[9]);
    check_val("alu_operand_a_o", alu_operand_a_o, f[10]);
    check_val("alu_operand_b_o", alu_operand_b_o, f[11]);
    check_val("rf_raddr_a_o", 32'(rf_raddr_a_o), f[12]);
    check_val("rf_raddr_b_o", 32'(rf_raddr_b_o), f[13]);
    check_val("rf_ren_a_o", 32'(rf_ren_a_o), f[14]);
    check_val("rf_ren_b_o", 32'(rf_ren_b_o), f[15]);
    check_val("rf_waddr_o", 32'(rf_waddr_o), f[16]);
    check_val("lsu_req_o", 32'(lsu_req_o), f[18]);
    check_val("lsu_we_o", 32'(lsu_we_o), f[19]);
    check_val("lsu_type_o", 32'(lsu_type_o), f[20]);
    check_val("lsu_sign_ext_o", 32'(lsu_sign_ext_o), f[21]);
    check_val("lsu_wdata_o", lsu_wdata_o, f[3]);
  endtask

  // Drive one instruction and follow it until done
  task automatic run_instr();
    int cyc;
    int set_count;
    int set_cycle;
    logic done;
    cyc       = 1;
    set_count = 0;
    set_cycle = 0;
    done      = 1'b0;
    @(posedge clk_i);
    instr_valid_i       <= 1'b1;
    instr_rdata_i       <= f[0];
    pc_id_i             <= f[1];
    rf_rdata_a_i        <= f[2];
    rf_rdata_b_i        <= f[3];
    branch_decision_i   <= f[4][0];
    lsu_resp_valid_i    <= 1'b0;
    lsu_addr_incr_req_i <= f[6][0];
    lsu_addr_last_i     <= f[7];
    @(negedge clk_i);
    check_first_cycle();
    while (!done) begin
      if (pc_set_o) begin
        set_count++;
        set_cycle = cyc;
      end
      if (cyc > 1) begin
        check_val("lsu_req_o", 32'(lsu_req_o), 32'd0);
      end
      if (cyc == 2) begin
        check_val("alu_operand_a_o", alu_operand_a_o, f[22]);
        check_val("alu_operand_b_o", alu_operand_b_o, f[23]);
      end
      // No write may show for x0, stores, branches or illegal encodings
      if (f[17] == 32'd0) begin
        check_val("rf_we_o", 32'(rf_we_o), 32'd0);
      end
      if (instr_id_done_o) begin
        done = 1'b1;
        check_val("rf_we_o", 32'(rf_we_o), f[17]);
        check_val("latency", 32'(cyc), f[25]);
      end else begin
        cyc++;
        if (cyc > 20) begin
          fail_run("instruction not done within 20 cycles");
        end
        // Response delay is counted in multi-cycle cycles starting at cycle 2
        @(posedge clk_i);
        lsu_resp_valid_i <= (cyc >= 2 + int'(f[5]));
        @(negedge clk_i);
      end
    end
    if (f[24] == 32'd0) begin
      check_val("pc_set_o pulses", 32'(set_count), 32'd0);
    end else begin
      check_val("pc_set_o pulses", 32'(set_count), 32'd1);
      check_val("pc_set_o cycle", 32'(set_cycle), f[24]);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int    fd;
    int    n;
    int    count;
    string line;
    rst_ni              = 1'b0;
    instr_valid_i       = 1'b0;
    instr_rdata_i       = '0;
    pc_id_i             = '0;
    branch_decision_i   = 1'b0;
    ex_valid_i          = 1'b1;
    lsu_resp_valid_i    = 1'b0;
    lsu_addr_incr_req_i = 1'b0;
    lsu_addr_last_i     = '0;
    rf_rdata_a_i        = '0;
    rf_rdata_b_i        = '0;
    count               = 0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    // Idle outputs after reset
    check_val("pc_set_o", 32'(pc_set_o), 32'd0);
    check_val("instr_id_done_o", 32'(instr_id_done_o), 32'd0);
    check_val("lsu_req_o", 32'(lsu_req_o), 32'd0);
    check_val("rf_we_o", 32'(rf_we_o), 32'd0);
    check_val("illegal_insn_o", 32'(illegal_insn_o), 32'd0);

    fd = $fopen("verif/id_stim.txt", "r");
    if (fd == 0) begin
      fail_run("cannot open verif/id_stim.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 1 && line[0] != "#") begin
        n = $sscanf(line,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
                    f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21],
                    f[22], f[23], f[24], f[25]);
        if (n != 26) begin
          fail_run("malformed line in stim file");
        end
        run_instr();
        count++;
      end
    end
    $fclose(fd);
    if (count == 0) begin
      fail_run("stim file holds no instructions");
    end

    @(posedge clk_i);
    instr_valid_i <= 1'b0;
    @(negedge clk_i);
    check_val("instr_id_done_o", 32'(instr_id_done_o), 32'd0);
    $display("%0d instructions checked", count);
    $display("Simulation passed");
    $finish;
  end

  // Guard against a stuck run
  initial begin
    #100us;
    fail_run("global timeout");
  end

endmodule

// ==== hdl/id_stage.sv ====
/*
 * Decode and execute-control stage of a small in-order RV32I core.
 * Sits between the fetch pipeline register and the ALU, LSU and register file.
 */

`timescale 1ns/1ps

module id_stage import id_pkg::*; #(
  parameter bit RV32E = 1'b0
) (
  input  logic      clk_i,
  input  logic      rst_ni,

  // From fetch
  input  logic      instr_valid_i,
  input  word_t     instr_rdata_i,
  input  word_t     pc_id_i,

  // Execute and LSU status
  input  logic      branch_decision_i,
  input  logic      ex_valid_i,
  input  logic      lsu_resp_valid_i,
  input  logic      lsu_addr_incr_req_i,
  input  word_t     lsu_addr_last_i,

  // Register file read data
  input  word_t     rf_rdata_a_i,
  input  word_t     rf_rdata_b_i,

  // Stage status
  output logic      illegal_insn_o,
  output logic      instr_first_cycle_o,
  output logic      instr_id_done_o,
  output logic      pc_set_o,

  // Register file
  output reg_addr_t rf_raddr_a_o,
  output reg_addr_t rf_raddr_b_o,
  output logic      rf_ren_a_o,
  output logic      rf_ren_b_o,
  output reg_addr_t rf_waddr_o,
  output logic      rf_we_o,

  // ALU
  output alu_op_e   alu_operator_o,
  output word_t     alu_operand_a_o,
  output word_t     alu_operand_b_o,

  // LSU
  output logic      lsu_req_o,
  output logic      lsu_we_o,
  output lsu_type_t lsu_type_o,
  output logic      lsu_sign_ext_o,
  output word_t     lsu_wdata_o
);

  // Decoder to operand path
  op_a_sel_e  op_a_sel;
  op_b_sel_e  op_b_sel;
  imm_b_sel_e imm_b_sel;

  // Decoder to FSM
  logic lsu_req_dec, branch_in_dec, jump_in_dec, rf_we_dec;

  ////////////////////////////////////////////////////////////
  // Decoder
  ////////////////////////////////////////////////////////////

  id_decoder #(
    .RV32E(RV32E)
  ) i_decoder (
    .instr_rdata_i      (instr_rdata_i),
    .instr_first_cycle_i(instr_first_cycle_o),
    .illegal_insn_o     (illegal_insn_o),
    .rf_raddr_a_o       (rf_raddr_a_o),
    .rf_raddr_b_o       (rf_raddr_b_o),
    .rf_waddr_o         (rf_waddr_o),
    .rf_ren_a_o         (rf_ren_a_o),
    .rf_ren_b_o         (rf_ren_b_o),
    .rf_we_o            (rf_we_dec),
    .alu_operator_o     (alu_operator_o),
    .op_a_sel_o         (op_a_sel),
    .op_b_sel_o         (op_b_sel),
    .imm_b_sel_o        (imm_b_sel),
    .lsu_req_o          (lsu_req_dec),
    .lsu_we_o           (lsu_we_o),
    .lsu_type_o         (lsu_type_o),
    .lsu_sign_ext_o     (lsu_sign_ext_o),
    .branch_in_dec_o    (branch_in_dec),
    .jump_in_dec_o      (jump_in_dec)
  );

  ////////////////////////////////////////////////////////////
  // Operands
  ////////////////////////////////////////////////////////////

  id_operands i_operands (
    .instr_rdata_i      (instr_rdata_i),
    .pc_id_i            (pc_id_i),
    .rf_rdata_a_i       (rf_rdata_a_i),
    .rf_rdata_b_i       (rf_rdata_b_i),
    .op_a_sel_i         (op_a_sel),
    .op_b_sel_i         (op_b_sel),
    .imm_b_sel_i        (imm_b_sel),
    .lsu_addr_incr_req_i(lsu_addr_incr_req_i),
    .lsu_addr_last_i    (lsu_addr_last_i),
    .alu_operand_a_o    (alu_operand_a_o),
    .alu_operand_b_o    (alu_operand_b_o)
  );

  ////////////////////////////////////////////////////////////
  // Stage FSM
  ////////////////////////////////////////////////////////////

  id_fsm i_fsm (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .instr_valid_i      (instr_valid_i),
    .illegal_insn_i     (illegal_insn_o),
    .lsu_req_dec_i      (lsu_req_dec),
    .branch_in_dec_i    (branch_in_dec),
    .jump_in_dec_i      (jump_in_dec),
    .rf_we_dec_i        (rf_we_dec),
    .branch_decision_i  (branch_decision_i),
    .ex_valid_i         (ex_valid_i),
    .lsu_resp_valid_i   (lsu_resp_valid_i),
    .instr_first_cycle_o(instr_first_cycle_o),
    .lsu_req_o          (lsu_req_o),
    .rf_we_o            (rf_we_o),
    .pc_set_o           (pc_set_o),
    .instr_id_done_o    (instr_id_done_o)
  );

  // Store data comes straight from the register file
  assign lsu_wdata_o = rf_rdata_b_i;

endmodule

// ==== hdl/id_fsm.sv ====
/*
 * First-cycle / multi-cycle sequencer of the decode stage.
 * Derives stalls, issues one PC set per branch or jump, gates LSU request
 * and register write, and flags the cycle that ends each instruction.
 */

`timescale 1ns/1ps

module id_fsm import id_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,

  input  logic instr_valid_i,
  input  logic illegal_insn_i,

  // Decoder classes
  input  logic lsu_req_dec_i,
  input  logic branch_in_dec_i,
  input  logic jump_in_dec_i,
  input  logic rf_we_dec_i,

  // Execute and LSU status
  input  logic branch_decision_i,
  input  logic ex_valid_i,
  input  logic lsu_resp_valid_i,

  output logic instr_first_cycle_o,
  output logic lsu_req_o,
  output logic rf_we_o,
  output logic pc_set_o,
  output logic instr_id_done_o
);

  id_fsm_e fsm_q, fsm_d;

  logic stall_mem, stall_branch, stall_jump, stall_id;
  logic multicycle_done;
  logic branch_set_d, branch_set_q;
  logic jump_set_raw;
  logic set_done_d, set_done_q;

  ////////////////////////////////////////////////////////////
  // State sequencing
  ////////////////////////////////////////////////////////////

  assign instr_first_cycle_o = instr_valid_i & (fsm_q == FIRST_CYCLE);

  // LSU instructions wait on the response, everything else on the EX stage
  assign multicycle_done = lsu_req_dec_i ? lsu_resp_valid_i : ex_valid_i;

  always_comb begin : next_state
    fsm_d        = fsm_q;
    stall_branch = 1'b0;
    stall_jump   = 1'b0;
    branch_set_d = 1'b0;
    jump_set_raw = 1'b0;

    if (instr_valid_i) begin
      unique case (fsm_q)
        FIRST_CYCLE: begin
          if (illegal_insn_i) begin
            fsm_d = FIRST_CYCLE;
          end else if (lsu_req_dec_i) begin
            fsm_d = MULTI_CYCLE;
          end else if (branch_in_dec_i) begin
            // Taken branch spends one more cycle on the target
            fsm_d        = branch_decision_i ? MULTI_CYCLE : FIRST_CYCLE;
            stall_branch = branch_decision_i;
            branch_set_d = branch_decision_i;
          end else if (jump_in_dec_i) begin
            // Target is ready now, link address next cycle
            fsm_d        = MULTI_CYCLE;
            stall_jump   = 1'b1;
            jump_set_raw = 1'b1;
          end
        end
        MULTI_CYCLE: begin
          if (multicycle_done) begin
            fsm_d = FIRST_CYCLE;
          end else begin
            stall_branch = branch_in_dec_i;
            stall_jump   = jump_in_dec_i;
          end
        end
        default: fsm_d = FIRST_CYCLE;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fsm_q <= FIRST_CYCLE;
    end else if (instr_valid_i) begin
      fsm_q <= fsm_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Branch and jump set
  ////////////////////////////////////////////////////////////

  // Held decision gives the taken-branch set in cycle 2
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      branch_set_q <= 1'b0;
    end else begin
      branch_set_q <= branch_set_d;
    end
  end

  // Remember a set already went out for this instruction
  assign set_done_d = (branch_set_q | jump_set_raw | set_done_q) & ~instr_id_done_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      set_done_q <= 1'b0;
    end else begin
      set_done_q <= set_done_d;
    end
  end

  assign pc_set_o = (branch_set_q | jump_set_raw) & ~set_done_q;

  ////////////////////////////////////////////////////////////
  // Stalls and execute gating
  ////////////////////////////////////////////////////////////

  // Memory ops always stall cycle 1, then until the response
  assign stall_mem = instr_valid_i & lsu_req_dec_i & (~lsu_resp_valid_i | instr_first_cycle_o);
  assign stall_id  = stall_mem | stall_branch | stall_jump;

  assign instr_id_done_o = instr_valid_i & ~stall_id;

  // Request only once, in the first cycle
  assign lsu_req_o = lsu_req_dec_i & instr_first_cycle_o;
  assign rf_we_o   = rf_we_dec_i & instr_valid_i & ~illegal_insn_i;

endmodule

// ==== hdl/id_operands.sv ====
/*
 * Immediate extraction and ALU operand muxes of the decode stage.
 * The LSU can take over both muxes to form the second misaligned address.
 */

`timescale 1ns/1ps

module id_operands import id_pkg::*; (
  input  word_t      instr_rdata_i,
  input  word_t      pc_id_i,
  input  word_t      rf_rdata_a_i,
  input  word_t      rf_rdata_b_i,

  // Selects from the decoder
  input  op_a_sel_e  op_a_sel_i,
  input  op_b_sel_e  op_b_sel_i,
  input  imm_b_sel_e imm_b_sel_i,

  // Misaligned access support
  input  logic       lsu_addr_incr_req_i,
  input  word_t      lsu_addr_last_i,

  output word_t      alu_operand_a_o,
  output word_t      alu_operand_b_o
);

  word_t imm_i, imm_s, imm_b, imm_u, imm_j;
  word_t imm_b_mux;

  op_a_sel_e  op_a_sel;
  op_b_sel_e  op_b_sel;
  imm_b_sel_e imm_b_sel;

  ////////////////////////////////////////////////////////////
  // Immediates
  ////////////////////////////////////////////////////////////

  assign imm_i = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:20]};
  assign imm_s = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:25], instr_rdata_i[11:7]};
  assign imm_b = {{19{instr_rdata_i[31]}}, instr_rdata_i[31], instr_rdata_i[7],
                  instr_rdata_i[30:25], instr_rdata_i[11:8], 1'b0};
  assign imm_u = {instr_rdata_i[31:12], 12'b0};
  assign imm_j = {{12{instr_rdata_i[31]}}, instr_rdata_i[19:12], instr_rdata_i[20],
                  instr_rdata_i[30:21], 1'b0};

  ////////////////////////////////////////////////////////////
  // Operand muxes
  ////////////////////////////////////////////////////////////

  // Second access of a split transfer is last address + 4
  assign op_a_sel  = lsu_addr_incr_req_i ? OP_A_FWD        : op_a_sel_i;
  assign op_b_sel  = lsu_addr_incr_req_i ? OP_B_IMM        : op_b_sel_i;
  assign imm_b_sel = lsu_addr_incr_req_i ? IMM_B_INCR_ADDR : imm_b_sel_i;

  always_comb begin : imm_b_select
    unique case (imm_b_sel)
      IMM_B_I: imm_b_mux = imm_i;
      IMM_B_S: imm_b_mux = imm_s;
      IMM_B_B: imm_b_mux = imm_b;
      IMM_B_U: imm_b_mux = imm_u;
      IMM_B_J: imm_b_mux = imm_j;
      // No compressed instructions, PC always moves by a word
      default: imm_b_mux = 32'd4;
    endcase
  end

  always_comb begin : op_a_select
    unique case (op_a_sel)
      OP_A_REG_A:  alu_operand_a_o = rf_rdata_a_i;
      OP_A_FWD:    alu_operand_a_o = lsu_addr_last_i;
      OP_A_CURRPC: alu_operand_a_o = pc_id_i;
      default:     alu_operand_a_o = '0;  // zero base for LUI
    endcase
  end

  assign alu_operand_b_o = (op_b_sel == OP_B_IMM) ? imm_b_mux : rf_rdata_b_i;

endmodule

// ==== hdl/id_decoder.sv ====
/*
 * Combinational RV32I decoder for the decode stage.
 * Turns opcode, funct3 and funct7 into register, ALU and LSU controls and
 * selects per-cycle operands for branches and jumps.
 */

`timescale 1ns/1ps

module id_decoder import id_pkg::*; #(
  parameter bit RV32E = 1'b0
) (
  input  word_t      instr_rdata_i,
  input  logic       instr_first_cycle_i,

  output logic       illegal_insn_o,

  // Register file
  output reg_addr_t  rf_raddr_a_o,
  output reg_addr_t  rf_raddr_b_o,
  output reg_addr_t  rf_waddr_o,
  output logic       rf_ren_a_o,
  output logic       rf_ren_b_o,
  output logic       rf_we_o,

  // ALU control
  output alu_op_e    alu_operator_o,
  output op_a_sel_e  op_a_sel_o,
  output op_b_sel_e  op_b_sel_o,
  output imm_b_sel_e imm_b_sel_o,

  // LSU control
  output logic       lsu_req_o,
  output logic       lsu_we_o,
  output lsu_type_t  lsu_type_o,
  output logic       lsu_sign_ext_o,

  // Multi-cycle classes
  output logic       branch_in_dec_o,
  output logic       jump_in_dec_o
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rs1, rs2, rd;

  // Raw decode before the illegal check clears it
  logic illegal_dec, illegal_rv32e, illegal;
  logic ren_a_dec, ren_b_dec, we_dec;
  logic lsu_req_dec, branch_dec, jump_dec;

  assign opcode = opcode_e'(instr_rdata_i[6:0]);
  assign funct3 = instr_rdata_i[14:12];
  assign funct7 = instr_rdata_i[31:25];
  assign rs1    = instr_rdata_i[19:15];
  assign rs2    = instr_rdata_i[24:20];
  assign rd     = instr_rdata_i[11:7];

  ////////////////////////////////////////////////////////////
  // Opcode decode
  ////////////////////////////////////////////////////////////

  always_comb begin : decode
    illegal_dec    = 1'b0;
    ren_a_dec      = 1'b0;
    ren_b_dec      = 1'b0;
    we_dec         = 1'b0;
    lsu_req_dec    = 1'b0;
    branch_dec     = 1'b0;
    jump_dec       = 1'b0;
    alu_operator_o = ALU_ADD;
    op_a_sel_o     = OP_A_REG_A;
    op_b_sel_o     = OP_B_IMM;
    imm_b_sel_o    = IMM_B_I;
    lsu_we_o       = 1'b0;
    lsu_type_o     = LSU_WORD;
    lsu_sign_ext_o = 1'b0;

    unique case (opcode)
      // Zero plus U immediate
      OPCODE_LUI: begin
        op_a_sel_o  = OP_A_IMM;
        imm_b_sel_o = IMM_B_U;
        we_dec      = 1'b1;
      end
      OPCODE_AUIPC: begin
        op_a_sel_o  = OP_A_CURRPC;
        imm_b_sel_o = IMM_B_U;
        we_dec      = 1'b1;
      end
      // Target first, link address PC + 4 after
      OPCODE_JAL: begin
        jump_dec    = 1'b1;
        we_dec      = 1'b1;
        op_a_sel_o  = OP_A_CURRPC;
        imm_b_sel_o = instr_first_cycle_i ? IMM_B_J : IMM_B_INCR_PC;
      end
      OPCODE_JALR: begin
        jump_dec    = 1'b1;
        we_dec      = 1'b1;
        ren_a_dec   = 1'b1;
        illegal_dec = (funct3 != 3'b000);
        if (instr_first_cycle_i) begin
          imm_b_sel_o = IMM_B_I;
        end else begin
          op_a_sel_o  = OP_A_CURRPC;
          imm_b_sel_o = IMM_B_INCR_PC;
        end
      end
      OPCODE_BRANCH: begin
        branch_dec = 1'b1;
        ren_a_dec  = 1'b1;
        ren_b_dec  = 1'b1;
        unique case (funct3)
          3'b000:  alu_operator_o = ALU_EQ;
          3'b001:  alu_operator_o = ALU_NE;
          3'b100:  alu_operator_o = ALU_LT;
          3'b101:  alu_operator_o = ALU_GE;
          3'b110:  alu_operator_o = ALU_LTU;
          3'b111:  alu_operator_o = ALU_GEU;
          default: illegal_dec    = 1'b1;
        endcase
        // Compare registers first, then add PC and B immediate
        if (instr_first_cycle_i) begin
          op_b_sel_o = OP_B_REG_B;
        end else begin
          alu_operator_o = ALU_ADD;
          op_a_sel_o     = OP_A_CURRPC;
          imm_b_sel_o    = IMM_B_B;
        end
      end
      OPCODE_LOAD: begin
        lsu_req_dec    = 1'b1;
        ren_a_dec      = 1'b1;
        we_dec         = 1'b1;
        lsu_sign_ext_o = ~funct3[2];
        unique case (funct3)
          3'b000, 3'b100: lsu_type_o  = LSU_BYTE;
          3'b001, 3'b101: lsu_type_o  = LSU_HALF;
          3'b010:         lsu_type_o  = LSU_WORD;
          default:        illegal_dec = 1'b1;
        endcase
      end
      OPCODE_STORE: begin
        lsu_req_dec = 1'b1;
        lsu_we_o    = 1'b1;
        ren_a_dec   = 1'b1;
        ren_b_dec   = 1'b1;
        imm_b_sel_o = IMM_B_S;
        unique case (funct3)
          3'b000:  lsu_type_o  = LSU_BYTE;
          3'b001:  lsu_type_o  = LSU_HALF;
          3'b010:  lsu_type_o  = LSU_WORD;
          default: illegal_dec = 1'b1;
        endcase
      end
      OPCODE_OP_IMM: begin
        ren_a_dec = 1'b1;
        we_dec    = 1'b1;
        unique case (funct3)
          3'b000: alu_operator_o = ALU_ADD;
          3'b010: alu_operator_o = ALU_SLT;
          3'b011: alu_operator_o = ALU_SLTU;
          3'b100: alu_operator_o = ALU_XOR;
          3'b110: alu_operator_o = ALU_OR;
          3'b111: alu_operator_o = ALU_AND;
          // Shift amount fits in 5 bits, upper bits must be clear
          3'b001: begin
            alu_operator_o = ALU_SLL;
            illegal_dec    = (funct7 != 7'h00);
          end
          default: begin
            alu_operator_o = funct7[5] ? ALU_SRA : ALU_SRL;
            illegal_dec    = (funct7 != 7'h00) && (funct7 != 7'h20);
          end
        endcase
      end
      OPCODE_OP: begin
        ren_a_dec  = 1'b1;
        ren_b_dec  = 1'b1;
        we_dec     = 1'b1;
        op_b_sel_o = OP_B_REG_B;
        unique case ({funct7, funct3})
          {7'h00, 3'b000}: alu_operator_o = ALU_ADD;
          {7'h20, 3'b000}: alu_operator_o = ALU_SUB;
          {7'h00, 3'b001}: alu_operator_o = ALU_SLL;
          {7'h00, 3'b010}: alu_operator_o = ALU_SLT;
          {7'h00, 3'b011}: alu_operator_o = ALU_SLTU;
          {7'h00, 3'b100}: alu_operator_o = ALU_XOR;
          {7'h00, 3'b101}: alu_operator_o = ALU_SRL;
          {7'h20, 3'b101}: alu_operator_o = ALU_SRA;
          {7'h00, 3'b110}: alu_operator_o = ALU_OR;
          {7'h00, 3'b111}: alu_operator_o = ALU_AND;
          default:         illegal_dec    = 1'b1;
        endcase
      end
      default: illegal_dec = 1'b1;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Illegal check and enables
  ////////////////////////////////////////////////////////////

  // Reduced register file only has x0..x15
  assign illegal_rv32e = RV32E & ((ren_a_dec & rs1[4]) | (ren_b_dec & rs2[4]) | (we_dec & rd[4]));
  assign illegal       = illegal_dec | illegal_rv32e;

  // Illegal encodings never leave the first cycle, so this also covers instr_valid
  assign illegal_insn_o = illegal & instr_first_cycle_i;

  assign rf_raddr_a_o = rs1;
  assign rf_raddr_b_o = rs2;
  assign rf_waddr_o   = rd;

  // Everything that acts is cleared for an illegal instruction
  assign rf_ren_a_o      = ren_a_dec & ~illegal;
  assign rf_ren_b_o      = ren_b_dec & ~illegal;
  // Writes to x0 are dropped here
  assign rf_we_o         = we_dec & ~illegal & (rd != 5'd0);
  assign lsu_req_o       = lsu_req_dec & ~illegal;
  assign branch_in_dec_o = branch_dec & ~illegal;
  assign jump_in_dec_o   = jump_dec & ~illegal;

endmodule

// ==== hdl/id_pkg.sv ====
/*
 * Shared types and encodings of the decode and execute-control stage.
 * Imported by every stage module through a wildcard import in its header.
 */

package id_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Data, address and instruction word
  typedef logic [31:0] word_t;
  // Register file index
  typedef logic [4:0]  reg_addr_t;
  // LSU access size
  typedef logic [1:0]  lsu_type_t;

  // Access size codes seen by the LSU
  localparam lsu_type_t LSU_WORD = 2'd0;
  localparam lsu_type_t LSU_HALF = 2'd2;
  localparam lsu_type_t LSU_BYTE = 2'd3;

  ////////////////////////////////////////////////////////////
  // Opcodes and selectors
  ////////////////////////////////////////////////////////////

  // Major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    OPCODE_LOAD   = 7'h03,
    OPCODE_OP_IMM = 7'h13,
    OPCODE_AUIPC  = 7'h17,
    OPCODE_STORE  = 7'h23,
    OPCODE_OP     = 7'h33,
    OPCODE_LUI    = 7'h37,
    OPCODE_BRANCH = 7'h63,
    OPCODE_JALR   = 7'h67,
    OPCODE_JAL    = 7'h6f
  } opcode_e;

  // ALU operator, arithmetic first, then branch compares
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  // Operand A source
  typedef enum logic [1:0] {OP_A_REG_A, OP_A_FWD, OP_A_CURRPC, OP_A_IMM} op_a_sel_e;

  // Operand B source
  typedef enum logic {OP_B_REG_B, OP_B_IMM} op_b_sel_e;

  // Immediate fed to operand B
  typedef enum logic [2:0] {
    IMM_B_I, IMM_B_S, IMM_B_B, IMM_B_U, IMM_B_J, IMM_B_INCR_PC, IMM_B_INCR_ADDR
  } imm_b_sel_e;

  // Stage state
  typedef enum logic {FIRST_CYCLE, MULTI_CYCLE} id_fsm_e;

endpackage
